/* common/async_wb_macros.svh */
//----------------------------------------------------------
// widths and sizes for the async wishbone bridge and target
// fifo depths must be powers of two, at least 2
//----------------------------------------------------------
`ifndef ASYNC_WB_MACROS_SVH
`define ASYNC_WB_MACROS_SVH

// wishbone bus widths
`define WB_AW 32 // byte address
`define WB_DW 32 // data word
`define WB_SW 4  // one select bit per byte

// bridge fifo depths
`define CMD_FIFO_DP  4 // request path, reads and writes
`define RESP_FIFO_DP 2 // read return path, one entry in use at most

// sram target size in words
`define TGT_WORDS 64

`endif

/* common/wb_bus_pkg.sv */
//----------------------------------------------------------
// bus-side types shared by the bridge and the target
// field order of the structs sets the fifo bit layout
//----------------------------------------------------------
`default_nettype none

`include "async_wb_macros.svh"

package wb_bus_pkg;

  // one queued request, 71 bits at default widths
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic [`WB_AW-1:0] adr;
    logic              we;
    logic [`WB_DW-1:0] dat;
    logic [`WB_SW-1:0] sel;
  } wb_cmd_t;

  // read response, error flag on top of the data word
  typedef struct packed {
    logic              err;
    logic [`WB_DW-1:0] dat;
  } wb_resp_t;

  // access kind, encoded like the we bit
  typedef enum logic {
    ACC_RD = 1'b0,
    ACC_WR = 1'b1
  } wb_acc_e;

endpackage

`default_nettype wire

/* common/wb_target_pkg.sv */
//----------------------------------------------------------
// target-side types for the sram target
//----------------------------------------------------------
`default_nettype none

package wb_target_pkg;

  // request handling fsm
  typedef enum logic [1:0] {
    TGT_IDLE = 2'd0, // waiting for cyc and stb
    TGT_WAIT = 2'd1, // single wait state, memory access
    TGT_RESP = 2'd2  // ack (and err) for one cycle
  } tgt_state_e;

  // address decode result
  typedef enum logic {
    DEC_MEM = 1'b0, // word index inside the array
    DEC_OOR = 1'b1  // out of range, err response
  } tgt_dec_e;

endpackage

`default_nettype wire

/* common/wb_if.sv */
//----------------------------------------------------------
// classic wishbone bus, single accesses only
// initiator holds the request until ack or err
//----------------------------------------------------------
`default_nettype none

`include "async_wb_macros.svh"

interface wb_if;

  // request side
  logic              cyc;
  logic              stb;
  logic [`WB_AW-1:0] adr;
  logic              we;
  logic [`WB_DW-1:0] dat_w;
  logic [`WB_SW-1:0] sel;

  // response side
  logic [`WB_DW-1:0] dat_r;
  logic              ack; // one cycle per request
  logic              err; // only together with ack

  modport initiator (
    output cyc, stb, adr, we, dat_w, sel,
    input  dat_r, ack, err
  );

  modport target (
    input  cyc, stb, adr, we, dat_w, sel,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

/* hw/async_fifo/async_fifo.sv */
//----------------------------------------------------------
// dual-clock fifo, gray pointers, two-flop synchronizers
// DP must be a power of two and at least 2; flags are pessimistic
//----------------------------------------------------------
`default_nettype none

module async_fifo #(
  parameter int W  = 8, // entry width
  parameter int DP = 4  // entry count
) (
  // write domain
  input  logic         wr_clk_i,
  input  logic         wr_rst_n_i,
  input  logic         wr_en_i,
  input  logic [W-1:0] wr_data_i,
  output logic         full_o,
  output logic         afull_o,

  // read domain
  input  logic         rd_clk_i,
  input  logic         rd_rst_n_i,
  input  logic         rd_en_i,
  output logic [W-1:0] rd_data_o,
  output logic         empty_o,
  output logic         aempty_o
);

  localparam int AW = $clog2(DP); // store index width
  localparam int PW = AW + 1;     // pointer width with wrap bit

  function automatic logic [PW-1:0] bin2gray(input logic [PW-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
    logic [PW-1:0] b;
    b[PW-1] = g[PW-1];
    for (int i = PW - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  logic [W-1:0]  mem_q [DP]; // register array store

  //----------------------------------------------------------
  // write side
  //----------------------------------------------------------
  logic [PW-1:0] wr_bin_q;
  logic [PW-1:0] wr_bin_nxt;
  logic [PW-1:0] wr_gray_q;    // crosses to read domain
  logic [PW-1:0] rd_gray_q;    // crosses to write domain
  logic [PW-1:0] rd_gray_s1_q; // read pointer after first sync stage
  logic [PW-1:0] rd_gray_s2_q;
  logic [PW-1:0] wr_cnt;       // fill level as seen by writer
  logic          wr_push;

  assign wr_push    = wr_en_i & ~full_o; // overflow dropped
  assign wr_bin_nxt = wr_bin_q + 1'b1;

  always_ff @(posedge wr_clk_i) begin
    if (!wr_rst_n_i) begin
      wr_bin_q     <= '0;
      wr_gray_q    <= '0;
      rd_gray_s1_q <= '0;
      rd_gray_s2_q <= '0;
    end else begin
      rd_gray_s1_q <= rd_gray_q;
      rd_gray_s2_q <= rd_gray_s1_q;
      if (wr_push) begin
        wr_bin_q  <= wr_bin_nxt;
        wr_gray_q <= bin2gray(wr_bin_nxt);
      end
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (wr_push) begin
      mem_q[wr_bin_q[AW-1:0]] <= wr_data_i;
    end
  end

  assign wr_cnt  = wr_bin_q - gray2bin(rd_gray_s2_q);
  assign full_o  = (wr_cnt == PW'(DP));
  assign afull_o = (wr_cnt >= PW'(DP - 1)); // one entry of margin

  //----------------------------------------------------------
  // read side
  //----------------------------------------------------------
  logic [PW-1:0] rd_bin_q;
  logic [PW-1:0] rd_bin_nxt;
  logic [PW-1:0] wr_gray_s1_q;
  logic [PW-1:0] wr_gray_s2_q;
  logic [PW-1:0] rd_cnt;       // fill level as seen by reader
  logic          rd_pop;

  assign rd_pop     = rd_en_i & ~empty_o; // underflow ignored
  assign rd_bin_nxt = rd_bin_q + 1'b1;

  always_ff @(posedge rd_clk_i) begin
    if (!rd_rst_n_i) begin
      rd_bin_q     <= '0;
      rd_gray_q    <= '0;
      wr_gray_s1_q <= '0;
      wr_gray_s2_q <= '0;
    end else begin
      wr_gray_s1_q <= wr_gray_q;
      wr_gray_s2_q <= wr_gray_s1_q;
      if (rd_pop) begin
        rd_bin_q  <= rd_bin_nxt;
        rd_gray_q <= bin2gray(rd_bin_nxt);
      end
    end
  end

  assign rd_cnt    = gray2bin(wr_gray_s2_q) - rd_bin_q;
  assign empty_o   = (rd_cnt == '0);
  assign aempty_o  = (rd_cnt <= PW'(1));
  assign rd_data_o = mem_q[rd_bin_q[AW-1:0]]; // head entry is valid when not empty

endmodule

`default_nettype wire

/* hw/async_wb/async_wb.sv */
//----------------------------------------------------------
// async wishbone bridge, posted writes and blocking reads
// one master, classic single cycles only
//----------------------------------------------------------
`default_nettype none

`include "async_wb_macros.svh"

module async_wb
  import wb_bus_pkg::*;
(
  // master side
  input  logic              wbm_clk_i,
  input  logic              wbm_rst_n,
  input  logic              wbm_cyc_i,
  input  logic              wbm_stb_i,
  input  logic [`WB_AW-1:0] wbm_adr_i,
  input  logic              wbm_we_i,
  input  logic [`WB_DW-1:0] wbm_dat_i,
  input  logic [`WB_SW-1:0] wbm_sel_i,
  output logic [`WB_DW-1:0] wbm_dat_o,
  output logic              wbm_ack_o,
  output logic              wbm_err_o,

  // slave side
  input  logic              wbs_clk_i,
  input  logic              wbs_rst_n,
  wb_if.initiator           wbs
);

  //----------------------------------------------------------
  // master domain
  //----------------------------------------------------------
  wb_cmd_t  m_cmd;        // packed request
  wb_resp_t m_resp;       // head of response fifo
  wb_acc_e  m_acc;
  logic     m_req;
  logic     m_cmd_push;
  logic     m_cmd_full;
  logic     m_cmd_afull;
  logic     m_resp_empty;
  logic     m_rd_ack;
  logic     rd_pend_q;    // read issued, waiting for data

  assign m_req = wbm_cyc_i & wbm_stb_i;
  assign m_acc = wb_acc_e'(wbm_we_i);

  always_comb begin
    m_cmd.cyc = wbm_cyc_i;
    m_cmd.stb = wbm_stb_i;
    m_cmd.adr = wbm_adr_i;
    m_cmd.we  = wbm_we_i;
    m_cmd.dat = wbm_dat_i;
    m_cmd.sel = wbm_sel_i;
  end

  // keep one slot free, never push behind an open read
  assign m_cmd_push = m_req & ~rd_pend_q & ~m_cmd_full & ~m_cmd_afull;

  always_ff @(posedge wbm_clk_i) begin
    if (!wbm_rst_n) begin
      rd_pend_q <= 1'b0;
    end else if (m_cmd_push && (m_acc == ACC_RD)) begin
      rd_pend_q <= 1'b1; // read is on its way
    end else if (m_rd_ack) begin
      rd_pend_q <= 1'b0;
    end
  end

  assign m_rd_ack  = m_req & (m_acc == ACC_RD) & rd_pend_q & ~m_resp_empty;
  assign wbm_ack_o = (m_acc == ACC_WR) ? m_cmd_push : m_rd_ack; // write acked on push
  assign wbm_dat_o = m_resp.dat;
  assign wbm_err_o = m_rd_ack & m_resp.err;

  //----------------------------------------------------------
  // slave domain
  //----------------------------------------------------------
  wb_cmd_t  s_cmd;        // head command
  wb_resp_t s_resp;
  logic     s_cmd_empty;
  logic     s_resp_push;
  logic     s_resp_full;

  // replay head command, bus idle while fifo is empty
  assign wbs.cyc   = s_cmd_empty ? 1'b0 : s_cmd.cyc;
  assign wbs.stb   = s_cmd_empty ? 1'b0 : s_cmd.stb;
  assign wbs.adr   = s_cmd_empty ? '0 : s_cmd.adr;
  assign wbs.we    = s_cmd_empty ? 1'b0 : s_cmd.we;
  assign wbs.dat_w = s_cmd_empty ? '0 : s_cmd.dat;
  assign wbs.sel   = s_cmd_empty ? '0 : s_cmd.sel;

  // only reads send something back
  assign s_resp_push = wbs.ack & (wb_acc_e'(s_cmd.we) == ACC_RD) & ~s_resp_full;
  assign s_resp.err  = wbs.err;
  assign s_resp.dat  = wbs.dat_r;

  async_fifo #(.W($bits(wb_cmd_t)), .DP(`CMD_FIFO_DP)) u_cmd_fifo (
    .wr_clk_i   (wbm_clk_i),
    .wr_rst_n_i (wbm_rst_n),
    .wr_en_i    (m_cmd_push),
    .wr_data_i  (m_cmd),
    .full_o     (m_cmd_full),
    .afull_o    (m_cmd_afull),
    .rd_clk_i   (wbs_clk_i),
    .rd_rst_n_i (wbs_rst_n),
    .rd_en_i    (wbs.ack),      // target ack retires the head
    .rd_data_o  (s_cmd),
    .empty_o    (s_cmd_empty),
    .aempty_o   ()
  );

  // blocking reads keep at most one entry in flight
  async_fifo #(.W($bits(wb_resp_t)), .DP(`RESP_FIFO_DP)) u_resp_fifo (
    .wr_clk_i   (wbs_clk_i),
    .wr_rst_n_i (wbs_rst_n),
    .wr_en_i    (s_resp_push),
    .wr_data_i  (s_resp),
    .full_o     (s_resp_full),
    .afull_o    (),
    .rd_clk_i   (wbm_clk_i),
    .rd_rst_n_i (wbm_rst_n),
    .rd_en_i    (m_rd_ack),
    .rd_data_o  (m_resp),
    .empty_o    (m_resp_empty),
    .aempty_o   ()
  );

endmodule

`default_nettype wire

/* hw/wb_sram_target.sv */
//----------------------------------------------------------
// word-wide sram target, one wait state, ack two cycles after stb
// word index at or above TGT_WORDS gets err with zero data
//----------------------------------------------------------
`default_nettype none

`include "async_wb_macros.svh"

module wb_sram_target
  import wb_bus_pkg::*;
  import wb_target_pkg::*;
(
  input  logic wbs_clk_i,
  input  logic wbs_rst_n,
  wb_if.target bus
);

  localparam int IW = $clog2(`TGT_WORDS); // word index width

  tgt_state_e        state_q;
  tgt_dec_e          dec;     // decode of the live address
  tgt_dec_e          dec_q;
  wb_acc_e           acc_q;
  logic              req;
  logic [IW-1:0]     idx_q;   // latched word index
  logic [`WB_DW-1:0] dat_q;   // latched write data
  logic [`WB_SW-1:0] sel_q;
  logic [`WB_DW-1:0] rd_q;    // read data for the response cycle
  logic [`WB_DW-1:0] mem_q [`TGT_WORDS];

  assign req = bus.cyc & bus.stb;
  assign dec = (bus.adr[`WB_AW-1:2] < `TGT_WORDS) ? DEC_MEM : DEC_OOR; // word index

  //----------------------------------------------------------
  // fsm
  //----------------------------------------------------------
  always_ff @(posedge wbs_clk_i) begin
    if (!wbs_rst_n) begin
      state_q <= TGT_IDLE;
    end else begin
      case (state_q)
        TGT_IDLE: if (req) state_q <= TGT_WAIT;
        TGT_WAIT: state_q <= TGT_RESP;
        TGT_RESP: state_q <= TGT_IDLE; // bus head moves on this edge
        default:  state_q <= TGT_IDLE;
      endcase
    end
  end

  // request capture, held stable anyway by the initiator
  always_ff @(posedge wbs_clk_i) begin
    if ((state_q == TGT_IDLE) && req) begin
      idx_q <= bus.adr[IW+1:2];
      dec_q <= dec;
      acc_q <= wb_acc_e'(bus.we);
      dat_q <= bus.dat_w;
      sel_q <= bus.sel;
    end
  end

  //----------------------------------------------------------
  // memory access in the wait state
  //----------------------------------------------------------
  always_ff @(posedge wbs_clk_i) begin
    if (state_q == TGT_WAIT) begin
      if ((dec_q == DEC_MEM) && (acc_q == ACC_WR)) begin
        for (int b = 0; b < `WB_SW; b++) begin
          if (sel_q[b]) begin
            mem_q[idx_q][8*b +: 8] <= dat_q[8*b +: 8]; // enabled bytes only
          end
        end
      end
      rd_q <= (dec_q == DEC_MEM) ? mem_q[idx_q] : '0; // old word, zero when oor
    end
  end

  assign bus.ack   = (state_q == TGT_RESP);
  assign bus.err   = (state_q == TGT_RESP) & (dec_q == DEC_OOR);
  assign bus.dat_r = rd_q;

endmodule

`default_nettype wire

/* hw/async_wb_top.sv */
//----------------------------------------------------------
// bridge plus sram target, master side as plain ports
// each clock domain has its own synchronous reset
//----------------------------------------------------------
`default_nettype none

`include "async_wb_macros.svh"

module async_wb_top (
  // master domain
  input  logic              wbm_clk_i,
  input  logic              wbm_rst_n,
  input  logic              wbm_cyc_i,
  input  logic              wbm_stb_i,
  input  logic [`WB_AW-1:0] wbm_adr_i,
  input  logic              wbm_we_i,
  input  logic [`WB_DW-1:0] wbm_dat_i,
  input  logic [`WB_SW-1:0] wbm_sel_i,
  output logic [`WB_DW-1:0] wbm_dat_o,
  output logic              wbm_ack_o,
  output logic              wbm_err_o,

  // slave domain
  input  logic              wbs_clk_i,
  input  logic              wbs_rst_n
);

  wb_if wbs_bus (); // slave-side wishbone

  async_wb u_bridge (
    .wbm_clk_i (wbm_clk_i),
    .wbm_rst_n (wbm_rst_n),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o),
    .wbs_clk_i (wbs_clk_i),
    .wbs_rst_n (wbs_rst_n),
    .wbs       (wbs_bus.initiator)
  );

  wb_sram_target u_target (
    .wbs_clk_i (wbs_clk_i),
    .wbs_rst_n (wbs_rst_n),
    .bus       (wbs_bus.target)
  );

endmodule

`default_nettype wire

/* dv/tb_async_wb_tasks.svh */
//----------------------------------------------------------
// master driver tasks and directed tests, included in tb_async_wb
// each task starts right after a rising wbm_clk_i edge
//----------------------------------------------------------
`ifndef TB_ASYNC_WB_TASKS_SVH
`define TB_ASYNC_WB_TASKS_SVH

// ack is combinational, sampled mid-cycle where it is settled
task automatic wait_ack(input string what, input adr_t adr);
  int cnt;
  bit done;
  cnt  = 0;
  done = 1'b0;
  while (!done) begin
    @(negedge wbm_clk_i);
    if (wbm_ack_o === 1'b1) begin
      done = 1'b1;
    end else begin
      cnt++;
      if (cnt > ACK_TIMEOUT) begin
        $display("timeout: the %s at address %h was never acked", what, adr);
        err_cnt++;
        finish_run();
      end
    end
  end
endtask

// target rule, enabled bytes of in-range words only
task automatic model_write(input adr_t adr, input dat_t dat, input sel_t sel);
  if (adr[`WB_AW-1:2] < (`WB_AW-2)'(`TGT_WORDS)) begin
    for (int b = 0; b < `WB_SW; b++) begin
      if (sel[b]) model_mem[adr[IW+1:2]][8*b +: 8] = dat[8*b +: 8];
    end
  end
endtask

task automatic bus_idle();
  wbm_cyc_i <= 1'b0;
  wbm_stb_i <= 1'b0;
  wbm_we_i  <= 1'b0;
endtask

// request stays up, caller idles the bus or issues the next one
task automatic write_word(input adr_t adr, input dat_t dat, input sel_t sel);
  wbm_cyc_i <= 1'b1;
  wbm_stb_i <= 1'b1;
  wbm_we_i  <= 1'b1;
  wbm_adr_i <= adr;
  wbm_dat_i <= dat;
  wbm_sel_i <= sel;
  wait_ack("write", adr);
  check_val("wbm_err_o", 32'd0, 32'(wbm_err_o)); // posted, never an error
  @(posedge wbm_clk_i); // push on this edge
  model_write(adr, dat, sel);
endtask

task automatic read_word(input adr_t adr, input dat_t exp_dat, input logic exp_err);
  wbm_cyc_i <= 1'b1;
  wbm_stb_i <= 1'b1;
  wbm_we_i  <= 1'b0;
  wbm_adr_i <= adr;
  wbm_dat_i <= '0;
  wbm_sel_i <= '1;
  wait_ack("read", adr);
  check_val("wbm_dat_o", exp_dat, wbm_dat_o);
  check_val("wbm_err_o", 32'(exp_err), 32'(wbm_err_o));
  @(posedge wbm_clk_i); // response popped here
endtask

//----------------------------------------------------------
// directed tests
//----------------------------------------------------------
task automatic idle_after_reset();
  repeat (20) begin
    @(negedge wbm_clk_i);
    check_val("wbm_ack_o", 32'd0, 32'(wbm_ack_o));
    check_val("wbm_err_o", 32'd0, 32'(wbm_err_o));
  end
  @(posedge wbm_clk_i);
endtask

task automatic write_then_read();
  adr_t adrs [4];
  adrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0014, 32'h0000_00fc}; // incl. last word
  foreach (adrs[i]) write_word(adrs[i], take_bits(32), 4'hf);
  foreach (adrs[i]) read_word(adrs[i], model_mem[adrs[i][IW+1:2]], 1'b0);
  bus_idle();
endtask

task automatic byte_enable_merge();
  sel_t sel;
  write_word(32'h0000_0008, take_bits(32), 4'hf);
  sel = sel_t'(take_bits(4));
  if (sel == 4'h0 || sel == 4'hf) sel = 4'b0110; // keep it partial
  write_word(32'h0000_0008, take_bits(32), sel);
  read_word(32'h0000_0008, model_mem[2], 1'b0);
  bus_idle();
endtask

task automatic range_error();
  read_word(adr_t'(`TGT_WORDS * 4), '0, 1'b1); // first word past the end
  read_word(32'h8000_0000, '0, 1'b1);
  write_word(adr_t'(`TGT_WORDS * 4), take_bits(32), 4'hf); // index bits alias word 0
  read_word(32'h0000_0000, model_mem[0], 1'b0);
  bus_idle();
endtask

// slow slave fills the command fifo, acks get held back
task automatic backpressure_order();
  adr_t a;
  a = '0;
  wbs_half = 34;
  repeat (4) @(posedge wbm_clk_i);
  for (int i = 0; i < 8; i++) begin
    a = adr_t'(32'h40 + 4 * i);
    write_word(a, take_bits(32), 4'hf);
  end
  read_word(a, model_mem[a[IW+1:2]], 1'b0); // right behind the last write
  read_word(32'h0000_0040, model_mem[16], 1'b0);
  bus_idle();
endtask

`endif

/* dv/tb_async_wb.sv */
//----------------------------------------------------------
// directed testbench for the async wishbone bridge and sram target
// one master access at a time, every ack wait is bounded
//----------------------------------------------------------
`default_nettype none

`include "async_wb_macros.svh"

module tb_async_wb;

  localparam int ACK_TIMEOUT = 400; // master cycles per ack wait
  localparam int RST_CYCLES  = 16;
  localparam int IW          = $clog2(`TGT_WORDS);

  typedef logic [`WB_AW-1:0] adr_t;
  typedef logic [`WB_DW-1:0] dat_t;
  typedef logic [`WB_SW-1:0] sel_t;

  // dut ports
  logic wbm_clk_i;
  logic wbm_rst_n;
  logic wbm_cyc_i;
  logic wbm_stb_i;
  adr_t wbm_adr_i;
  logic wbm_we_i;
  dat_t wbm_dat_i;
  sel_t wbm_sel_i;
  dat_t wbm_dat_o;
  logic wbm_ack_o;
  logic wbm_err_o;
  logic wbs_clk_i;
  logic wbs_rst_n;

  int          wbs_half = 7;             // first half period skews the slave phase
  logic [31:0] lfsr_q;
  dat_t        model_mem [`TGT_WORDS];   // expected target contents
  int          err_cnt;
  int          chk_cnt;

  async_wb_top dut (
    .wbm_clk_i (wbm_clk_i),
    .wbm_rst_n (wbm_rst_n),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o),
    .wbs_clk_i (wbs_clk_i),
    .wbs_rst_n (wbs_rst_n)
  );

  //----------------------------------------------------------
  // clocks and resets
  //----------------------------------------------------------
  always #20 wbm_clk_i = ~wbm_clk_i;         // period 40
  always #(wbs_half) wbs_clk_i = ~wbs_clk_i; // 40, later 68

  initial begin
    wbs_rst_n = 1'b0;
    #1 wbs_half = 20; // phase is set, regular half period from here
    repeat (RST_CYCLES) @(posedge wbs_clk_i);
    wbs_rst_n <= 1'b1;
  end

  //----------------------------------------------------------
  // support
  //----------------------------------------------------------
  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  // summary line, verdict, end of run
  task automatic finish_run();
    $display("%0d checks done, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  `include "tb_async_wb_tasks.svh"

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------
  initial begin
    wbm_clk_i = 1'b0;
    wbs_clk_i = 1'b0;
    wbm_rst_n = 1'b0;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_adr_i = '0;
    wbm_we_i  = 1'b0;
    wbm_dat_i = '0;
    wbm_sel_i = '0;
    lfsr_q    = 32'hcb88;
    err_cnt   = 0;
    chk_cnt   = 0;
    repeat (RST_CYCLES) @(posedge wbm_clk_i);
    wbm_rst_n <= 1'b1;
    repeat (4) @(posedge wbm_clk_i); // slave reset is out by now too
    idle_after_reset();
    write_then_read();
    byte_enable_merge();
    range_error();
    backpressure_order();
    repeat (4) @(posedge wbm_clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
+incdir+dv
common/wb_bus_pkg.sv
common/wb_target_pkg.sv
common/wb_if.sv
hw/async_fifo/async_fifo.sv
hw/async_wb/async_wb.sv
hw/wb_sram_target.sv
hw/async_wb_top.sv
dv/tb_async_wb.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run, pass only when the pass line shows up
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_async_wb -o tb_async_wb &&
  ./obj_dir/tb_async_wb | tee /dev/stderr | grep -q "All checks passed" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
